// ==== source/mem_params.svh ====
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// data RAM size in 64-bit doublewords
`define MEM_DEPTH_WORDS 256

// extra access cycles before pready (0 to 3)
`define APB_WAIT_STATES 1

`endif

// ==== source/common.sv ====
package common;

    typedef logic [63:0] u64;
    typedef logic [3:0]  u4;

    typedef u64 addr_t;            // byte address
    typedef u64 word_t;            // one doubleword
    typedef logic [7:0] strobe_t;  // bit i enables byte lane i

    // bit 3 marks a store, bits 1:0 give the access width
    typedef enum u4 {
        LB  = 4'b0000,
        LH  = 4'b0001,
        LW  = 4'b0010,
        LD  = 4'b0011,
        LBU = 4'b0100,
        LHU = 4'b0101,
        LWU = 4'b0110,
        SB  = 4'b1000,
        SH  = 4'b1001,
        SW  = 4'b1010,
        SD  = 4'b1011
    } memMode_t;

    typedef struct packed {
        addr_t    addr;
        word_t    wdata;
        memMode_t mode;
    } memReq_t;

    typedef struct packed {
        word_t rdata;
        logic  err;
    } memResp_t;

    typedef struct packed {
        addr_t   paddr;
        logic    psel;
        logic    penable;
        logic    pwrite;
        word_t   pwdata;
        strobe_t pstrb;
    } apbReq_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
        logic  pslverr;
    } apbResp_t;

endpackage

// ==== source/memoryHelper.sv ====
module memoryHelper import common::*; (
    input  addr_t     addressReq,
    input  word_t     dataIn,
    input  memMode_t  memMode,
    output addr_t     addr,
    output strobe_t   strobe,
    output word_t     data,
    output logic      misaligned
);

    logic [2:0] off;
    logic [5:0] shamt;
    logic [1:0] size;

    assign off   = addressReq[2:0];
    assign shamt = {off, 3'b000};  // byte offset in bits
    assign size  = memMode[1:0];

    assign addr = {addressReq[63:3], 3'b000};

    // same natural alignment rule for loads and stores
    assign misaligned = (size == 2'd1 && off[0]) ||
                        (size == 2'd2 && off[1:0] != 2'b00) ||
                        (size == 2'd3 && off != 3'b000);

    always_comb begin
        strobe = '0;
        case (memMode)
            SB: strobe = strobe_t'(8'h01 << off);
            SH: begin
                if (!off[0]) strobe = strobe_t'(8'h03 << off);
            end
            SW: begin
                if (off[1:0] == 2'b00) strobe = strobe_t'(8'h0f << off);
            end
            SD: begin
                if (off == 3'b000) strobe = 8'hff;
            end
            default: strobe = '0;  // loads write nothing
        endcase
    end

    always_comb begin
        case (memMode)
            SB: data = {56'b0, dataIn[7:0]} << shamt;
            SH: begin
                data = off[0] ? '0 : ({48'b0, dataIn[15:0]} << shamt);
            end
            SW: begin
                data = (off[1:0] != 2'b00) ? '0 : ({32'b0, dataIn[31:0]} << shamt);
            end
            SD: begin
                data = (off != 3'b000) ? '0 : dataIn;
            end
            default: data = dataIn;
        endcase
    end

    // a legal store must touch at least one lane
    always_comb begin
        if (memMode[3] && !misaligned) begin
            assert (strobe != '0)
                else $error("aligned store with empty strobe, mode %b off %0d", memMode, off);
        end
    end

endmodule

// ==== source/loadExtract.sv ====
module loadExtract import common::*; (
    input  word_t      rdataRaw,
    input  logic [2:0] byteOffset,
    input  memMode_t   memMode,
    output word_t      rdata
);

    word_t shifted;

    assign shifted = rdataRaw >> {byteOffset, 3'b000};  // addressed lane to bit 0

    always_comb begin
        case (memMode)
            LB: begin
                rdata = {{56{shifted[7]}}, shifted[7:0]};
            end
            LH: begin
                rdata = {{48{shifted[15]}}, shifted[15:0]};
            end
            LW: begin
                rdata = {{32{shifted[31]}}, shifted[31:0]};
            end
            LBU: begin
                rdata = {56'b0, shifted[7:0]};
            end
            LHU: begin
                rdata = {48'b0, shifted[15:0]};
            end
            LWU: begin
                rdata = {32'b0, shifted[31:0]};
            end
            LD: begin
                rdata = rdataRaw;  // whole doubleword
            end
            default: begin
                rdata = rdataRaw;
            end
        endcase
    end

endmodule

// ==== source/memAccess.sv ====
module memAccess import common::*; (
    input  logic     clk,
    input  logic     rstN,
    input  memReq_t  req,
    input  logic     reqValid,
    output logic     reqReady,
    output memResp_t resp,
    output logic     respValid,
    output apbReq_t  apbReq,
    input  apbResp_t apbResp
);

    typedef enum logic [1:0] {IDLE, SETUP, ACCESS} state_t;

    state_t     state;
    logic       accept;
    addr_t      helperAddr;
    strobe_t    helperStrobe;
    word_t      helperData;
    logic       misaligned;
    addr_t      paddrQ;
    word_t      pwdataQ;
    strobe_t    pstrbQ;
    logic       pwriteQ;
    memMode_t   modeQ;
    logic [2:0] offsetQ;
    word_t      loadData;

    memoryHelper uHelper (
        .addressReq (req.addr),
        .dataIn     (req.wdata),
        .memMode    (req.mode),
        .addr       (helperAddr),
        .strobe     (helperStrobe),
        .data       (helperData),
        .misaligned (misaligned)
    );

    loadExtract uExtract (
        .rdataRaw   (apbResp.prdata),
        .byteOffset (offsetQ),
        .memMode    (modeQ),
        .rdata      (loadData)
    );

    assign reqReady = (state == IDLE);
    assign accept   = reqValid && reqReady;

    assign apbReq = '{paddr: paddrQ, psel: (state != IDLE), penable: (state == ACCESS),
                      pwrite: pwriteQ, pwdata: pwdataQ, pstrb: pstrbQ};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= IDLE;
            respValid <= 1'b0;
        end else begin
            respValid <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        if (misaligned) respValid <= 1'b1;  // answer without the bus
                        else state <= SETUP;
                    end
                end
                SETUP: state <= ACCESS;
                ACCESS: begin
                    if (apbResp.pready) begin
                        state     <= IDLE;
                        respValid <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            paddrQ  <= helperAddr;
            pwdataQ <= helperData;
            pstrbQ  <= helperStrobe;
            pwriteQ <= req.mode[3];
            modeQ   <= req.mode;
            offsetQ <= req.addr[2:0];  // kept for the load lane select
        end
        if (accept && misaligned) begin
            resp.rdata <= '0;
            resp.err   <= 1'b1;
        end else if (state == ACCESS && apbResp.pready) begin
            resp.rdata <= pwriteQ ? '0 : loadData;
            resp.err   <= apbResp.pslverr;
        end
    end

    // access phase only after a setup cycle
    apbSetupFirst: assert property (@(posedge clk) disable iff (!rstN)
        $rose(apbReq.penable) |-> $past(apbReq.psel && !apbReq.penable));

    // address must hold while the slave stalls
    apbAddrStable: assert property (@(posedge clk) disable iff (!rstN)
        (apbReq.penable && !apbResp.pready) |=> $stable(apbReq.paddr));

endmodule

// ==== source/dataRam.sv ====
`include "mem_params.svh"

module dataRam import common::*; (
    input  logic     clk,
    input  logic     rstN,
    input  apbReq_t  apbReq,
    output apbResp_t apbResp
);

    localparam int DEPTH = `MEM_DEPTH_WORDS;
    localparam int IDX_W = $clog2(DEPTH);
    localparam int WAIT  = `APB_WAIT_STATES;

    word_t            mem [DEPTH];
    logic [1:0]       waitCnt;
    logic [IDX_W-1:0] idx;
    logic             inRange;
    logic             accessPhase;
    logic             pready;

    assign idx         = apbReq.paddr[IDX_W+2:3];  // doubleword index
    assign inRange     = ({3'b000, apbReq.paddr[63:3]} < 64'(DEPTH));
    assign accessPhase = apbReq.psel && apbReq.penable;
    assign pready      = accessPhase && (waitCnt == WAIT[1:0]);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            waitCnt <= '0;
        end else if (accessPhase && !pready) begin
            waitCnt <= waitCnt + 2'd1;
        end else begin
            waitCnt <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (pready && apbReq.pwrite && inRange) begin
            for (int i = 0; i < 8; i++) begin
                if (apbReq.pstrb[i]) mem[idx][8*i +: 8] <= apbReq.pwdata[8*i +: 8];
            end
        end
    end

    assign apbResp.pready  = pready;
    assign apbResp.pslverr = pready && !inRange;  // address beyond the RAM
    assign apbResp.prdata  = (pready && !apbReq.pwrite && inRange) ? mem[idx] : '0;

endmodule

// ==== source/memUnit.sv ====
module memUnit import common::*; (
    input  logic     clk,
    input  logic     rstN,
    input  memReq_t  req,
    input  logic     reqValid,
    output logic     reqReady,
    output memResp_t resp,
    output logic     respValid
);

    apbReq_t  apbReq;
    apbResp_t apbResp;

    memAccess uAccess (
        .clk       (clk),
        .rstN      (rstN),
        .req       (req),
        .reqValid  (reqValid),
        .reqReady  (reqReady),
        .resp      (resp),
        .respValid (respValid),
        .apbReq    (apbReq),
        .apbResp   (apbResp)
    );

    dataRam uRam (
        .clk     (clk),
        .rstN    (rstN),
        .apbReq  (apbReq),
        .apbResp (apbResp)
    );

endmodule

// ==== dv/memUnitTb.sv ====
`include "mem_params.svh"

module memUnitTb import common::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH   = `MEM_DEPTH_WORDS;
    localparam int TIMEOUT = 20 + 4 * `APB_WAIT_STATES;  // cycles per wait loop

    logic     clk;
    logic     rstN;
    memReq_t  req;
    logic     reqValid;
    logic     reqReady;
    memResp_t resp;
    logic     respValid;

    logic [7:0] model [DEPTH*8];  // byte image of the RAM
    int         checks;
    int         errors;

    memUnit UUT (.clk(clk), .rstN(rstN), .req(req), .reqValid(reqValid),
                 .reqReady(reqReady), .resp(resp), .respValid(respValid));

    always #10 clk = ~clk;

    task automatic finishRun();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    task automatic checkValue(string name, u64 got, u64 expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic doAccess(addr_t addr, word_t wdata, memMode_t mode, output memResp_t result);
        int waited;
        @(posedge clk);
        req      <= '{addr: addr, wdata: wdata, mode: mode};
        reqValid <= 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!reqReady && waited < TIMEOUT);
        if (!reqReady) begin
            errors++;
            $display("timeout: request to %h was never accepted", addr);
            finishRun();
        end
        @(posedge clk);  // handshake edge
        reqValid <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!respValid && waited < TIMEOUT);
        if (!respValid) begin
            errors++;
            $display("timeout: no response for %s at %h", mode.name(), addr);
            finishRun();
        end
        result = resp;
    endtask

    function automatic word_t loadRef(addr_t addr, memMode_t mode);
        int    bytes;
        word_t value;
        bytes = 1 << mode[1:0];
        value = '0;
        for (int i = 0; i < bytes; i++) begin
            value[8*i +: 8] = model[int'(addr) + i];
        end
        if (!mode[2] && bytes < 8 && value[8*bytes-1]) begin
            value = value | (~64'd0 << (8 * bytes));  // sign fill
        end
        return value;
    endfunction

    function automatic void storeRef(addr_t addr, memMode_t mode, word_t wdata);
        for (int i = 0; i < (1 << mode[1:0]); i++) begin
            model[int'(addr) + i] = wdata[8*i +: 8];
        end
    endfunction

    task automatic accessAndCheck(addr_t addr, word_t wdata, memMode_t mode);
        memResp_t result;
        logic     errExp;
        word_t    dataExp;
        errExp  = ((addr & ((64'd1 << mode[1:0]) - 64'd1)) != '0) || ((addr >> 3) >= 64'(DEPTH));
        dataExp = (errExp || mode[3]) ? '0 : loadRef(addr, mode);
        if (mode[3] && !errExp) begin
            storeRef(addr, mode, wdata);
        end
        doAccess(addr, wdata, mode, result);
        checkValue($sformatf("resp.err %s @%h", mode.name(), addr), u64'(result.err),
                   u64'(errExp));
        checkValue($sformatf("resp.rdata %s @%h", mode.name(), addr), result.rdata, dataExp);
    endtask

    function automatic word_t fillPattern(addr_t a);
        return {a[31:0] ^ 32'h5ac3_96e1, ~a[31:0] + a[63:32]};
    endfunction

    task automatic fillMemory();
        for (int w = 0; w < DEPTH; w++) begin
            accessAndCheck(addr_t'(w * 8), fillPattern(addr_t'(w * 8)), SD);
        end
    endtask

    task automatic testDoubleRoundTrip();
        accessAndCheck(64'h40, 64'h0123_4567_89ab_cdef, SD);
        accessAndCheck(64'h40, '0, LD);
    endtask

    task automatic testPartialStores();
        accessAndCheck(64'h80, 64'h1111_2222_3333_4444, SD);
        accessAndCheck(64'h81, 64'hffff_ffff_ffff_ffa5, SB);
        accessAndCheck(64'h82, 64'hffff_ffff_ffff_b6c7, SH);
        accessAndCheck(64'h84, 64'h0000_0000_d8e9_fa0b, SW);
        accessAndCheck(64'h80, '0, LD);
    endtask

    task automatic testLoadExtension();
        accessAndCheck(64'hc0, 64'hf0e1_d2c3_b4a5_9687, SD);  // every byte has bit 7 set
        for (int off = 0; off < 8; off++) begin
            accessAndCheck(64'hc0 + addr_t'(off), '0, LB);
            accessAndCheck(64'hc0 + addr_t'(off), '0, LBU);
            if (off % 2 == 0) begin
                accessAndCheck(64'hc0 + addr_t'(off), '0, LH);
                accessAndCheck(64'hc0 + addr_t'(off), '0, LHU);
            end
            if (off % 4 == 0) begin
                accessAndCheck(64'hc0 + addr_t'(off), '0, LW);
                accessAndCheck(64'hc0 + addr_t'(off), '0, LWU);
            end
        end
    endtask

    task automatic testMisaligned();
        accessAndCheck(64'h100, 64'h8899_aabb_ccdd_eeff, SD);
        accessAndCheck(64'h101, '0, LH);
        accessAndCheck(64'h102, '0, LW);
        accessAndCheck(64'h104, '0, LD);
        accessAndCheck(64'h103, 64'h1234, SH);
        accessAndCheck(64'h106, 64'h5678_9abc, SW);
        accessAndCheck(64'h101, '1, SD);
        accessAndCheck(64'h100, '0, LD);
    endtask

    task automatic testOutOfRange();
        addr_t limit;
        limit = addr_t'(DEPTH * 8);
        accessAndCheck(limit, '1, SD);  // low index bits alias word 0
        accessAndCheck(limit + 64'd8, 64'hab, SB);
        accessAndCheck(limit, '0, LD);
        accessAndCheck(64'h1_0000_0000_0000, '0, LW);
        accessAndCheck(limit - 64'd8, '0, LD);
        accessAndCheck(64'h0, '0, LD);
        accessAndCheck(64'h8, '0, LD);
    endtask

    task automatic testRandom();
        memMode_t    mode;
        int unsigned pick;
        int unsigned offset;
        addr_t       addr;
        for (int n = 0; n < 200; n++) begin
            pick   = $urandom_range(10, 0);
            mode   = memMode_t'(4'((pick < 7) ? pick : pick + 1));  // skip the gap at code 7
            offset = $urandom_range(7, 0) & ~((32'd1 << mode[1:0]) - 32'd1);
            addr   = addr_t'($urandom_range(DEPTH - 1, 0)) * 64'd8 + addr_t'(offset);
            accessAndCheck(addr, {$urandom, $urandom}, mode);
        end
    endtask

    initial begin
        void'($urandom(32'hb083));
        clk      = 1'b0;
        rstN     = 1'b0;
        reqValid = 1'b0;
        req      = '0;
        checks   = 0;
        errors   = 0;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkValue("reqReady", u64'(reqReady), 64'd1);
        checkValue("respValid", u64'(respValid), 64'd0);
        fillMemory();
        testDoubleRoundTrip();
        testPartialStores();
        testLoadExtension();
        testMisaligned();
        testOutOfRange();
        testRandom();
        finishRun();
    end

endmodule

// ==== memUnit.f ====
+incdir+source
source/common.sv
source/memoryHelper.sv
source/loadExtract.sv
source/memAccess.sv
source/dataRam.sv
source/memUnit.sv
dv/memUnitTb.sv

// ==== Makefile ====
TB = memUnitTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f memUnit.f --top-module memUnit

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f memUnit.f \
		--top-module $(TB) -o $(TB)
	out="$$(./obj_dir/$(TB))"; echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
